/* hdl/dma_read_pkg.sv */
package dma_read_pkg;

  // Client and address geometry
  localparam int NUM_CLIENTS = 16;
  localparam int BEAT_ADDR_W = 27;
  localparam int AXI_ADDR_W = 32;

  // One 64-bit beat per read
  localparam int DATA_W = 64;
  localparam int BEAT_BYTES = 8;
  localparam int BEAT_SHIFT = 3;

  // Buffer depth doubles as the credit pool
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

  localparam int COOLDOWN_CYCLES = 4;

  typedef logic [NUM_CLIENTS-1:0] client_mask_t;
  typedef logic [PTR_W-1:0] ptr_t;

  // Occupancy or credit count, 0 to FIFO_DEPTH
  typedef logic [LEVEL_W-1:0] level_t;

  typedef struct packed {
    logic [BEAT_ADDR_W-1:0] start_addr;
    logic [BEAT_ADDR_W-1:0] beat_len;
  } read_cmd_t;

  typedef struct packed {
    logic [BEAT_ADDR_W-1:0] addr;
    client_mask_t           mask;
    logic                   last;
  } beat_cmd_t;

  // Travels beside the read in the tag FIFO
  typedef struct packed {
    client_mask_t mask;
    logic         last;
  } beat_tag_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    client_mask_t      en;
    logic              eop;
  } dout_beat_t;

  typedef enum logic {
    JOB_IDLE   = 1'b0,
    JOB_ACTIVE = 1'b1
  } job_state_e;

endpackage

/* hdl/sync_fifo.sv */
module sync_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [WIDTH-1:0] mem_q [dma_read_pkg::FIFO_DEPTH];
  dma_read_pkg::ptr_t wr_ptr_q;
  dma_read_pkg::ptr_t rd_ptr_q;
  dma_read_pkg::level_t count_q;

  always_ff @(posedge clk)
  begin
    if (wr_i)
      mem_q[wr_ptr_q] <= din_i;
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + dma_read_pkg::level_t'(wr_i) -
                 dma_read_pkg::level_t'(rd_i);
    end
  end

  // Show-ahead, head entry is always on the output
  assign dout_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == dma_read_pkg::level_t'(dma_read_pkg::FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  // Writer is paced by the credit counter upstream
  no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_i |-> !full_o);

  no_underflow: assert property (@(posedge clk) disable iff (rst)
    rd_i |-> !empty_o);

endmodule

/* hdl/read_arbiter.sv */
module read_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_read_pkg::client_mask_t read_req_i,
  input  logic                       job_busy_i,
  output dma_read_pkg::client_mask_t grant_o,
  output dma_read_pkg::client_mask_t read_ack_o
);

  dma_read_pkg::client_mask_t allow_q;
  dma_read_pkg::client_mask_t base_q;
  dma_read_pkg::client_mask_t grant_q;
  dma_read_pkg::client_mask_t ack_q;
  dma_read_pkg::client_mask_t cool_q [dma_read_pkg::COOLDOWN_CYCLES];
  dma_read_pkg::client_mask_t req_ok;
  dma_read_pkg::client_mask_t win;
  dma_read_pkg::client_mask_t grant_nxt;
  logic [2*dma_read_pkg::NUM_CLIENTS-1:0] dbl_req;
  logic [2*dma_read_pkg::NUM_CLIENTS-1:0] dbl_base;
  logic [2*dma_read_pkg::NUM_CLIENTS-1:0] dbl_pick;
  logic can_pick;

  assign req_ok = read_req_i & allow_q;

  // First requester at or above base, wrapping through the upper copy
  assign dbl_req  = {req_ok, req_ok};
  assign dbl_base = {{dma_read_pkg::NUM_CLIENTS{1'b0}}, base_q};
  assign dbl_pick = dbl_req & ~(dbl_req - dbl_base);
  assign win = dbl_pick[dma_read_pkg::NUM_CLIENTS-1:0] |
               dbl_pick[2*dma_read_pkg::NUM_CLIENTS-1:dma_read_pkg::NUM_CLIENTS];

  // Hold off while a grant is still on its way to the job register
  assign can_pick  = !job_busy_i && (grant_q == '0);
  assign grant_nxt = can_pick ? win : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_q <= '0;
      ack_q   <= '0;
      base_q  <= dma_read_pkg::client_mask_t'(1);
      allow_q <= '1;
    end
    else
    begin
      grant_q <= grant_nxt;
      ack_q   <= grant_q;
      allow_q <= (allow_q & ~grant_nxt) | cool_q[dma_read_pkg::COOLDOWN_CYCLES-1];
      if (grant_nxt != '0)
      begin
        base_q <= {grant_nxt[dma_read_pkg::NUM_CLIENTS-2:0],
                   grant_nxt[dma_read_pkg::NUM_CLIENTS-1]};
      end
    end
  end

  // Cooldown delay line, the last tap re-enables the client
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < dma_read_pkg::COOLDOWN_CYCLES; i++)
        cool_q[i] <= '0;
    end
    else
    begin
      cool_q[0] <= grant_q;
      for (int i = 1; i < dma_read_pkg::COOLDOWN_CYCLES; i++)
        cool_q[i] <= cool_q[i-1];
    end
  end

  assign grant_o    = grant_q;
  assign read_ack_o = ack_q;

  grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant_o));

  // Grant was picked from the request seen one edge earlier
  grant_requested: assert property (@(posedge clk) disable iff (rst)
    (grant_o & ~$past(read_req_i)) == '0);

endmodule

/* hdl/read_job_regs.sv */
module read_job_regs (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  dma_read_pkg::client_mask_t                              grant_i,
  input  dma_read_pkg::read_cmd_t [dma_read_pkg::NUM_CLIENTS-1:0] read_cmd_i,
  input  logic                                                    beat_take_i,
  output logic                                                    beat_valid_o,
  output dma_read_pkg::beat_cmd_t                                 beat_cmd_o,
  output logic                                                    job_busy_o
);

  dma_read_pkg::job_state_e state_q;
  dma_read_pkg::read_cmd_t sel_cmd;
  dma_read_pkg::client_mask_t mask_q;
  logic [dma_read_pkg::BEAT_ADDR_W-1:0] addr_q;
  logic [dma_read_pkg::BEAT_ADDR_W-1:0] left_q;
  logic last_beat;

  // Grant is one-hot, so an OR of the gated commands selects the winner
  always_comb
  begin
    sel_cmd = '0;
    for (int i = 0; i < dma_read_pkg::NUM_CLIENTS; i++)
    begin
      if (grant_i[i])
        sel_cmd = sel_cmd | read_cmd_i[i];
    end
  end

  assign last_beat = (left_q == dma_read_pkg::BEAT_ADDR_W'(1));

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= dma_read_pkg::JOB_IDLE;
    else if (grant_i != '0)
      state_q <= dma_read_pkg::JOB_ACTIVE;
    else if (beat_take_i && last_beat)
      state_q <= dma_read_pkg::JOB_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (grant_i != '0)
    begin
      addr_q <= sel_cmd.start_addr;
      left_q <= sel_cmd.beat_len;
      mask_q <= grant_i;
    end
    else if (beat_take_i)
    begin
      addr_q <= addr_q + 1'b1;
      left_q <= left_q - 1'b1;
    end
  end

  assign beat_valid_o    = (state_q == dma_read_pkg::JOB_ACTIVE);
  assign job_busy_o      = (state_q == dma_read_pkg::JOB_ACTIVE);
  assign beat_cmd_o.addr = addr_q;
  assign beat_cmd_o.mask = mask_q;
  assign beat_cmd_o.last = last_beat;

  // Arbiter must wait for the previous job to drain
  no_grant_when_active: assert property (@(posedge clk) disable iff (rst)
    (grant_i != '0) |-> (state_q == dma_read_pkg::JOB_IDLE));

endmodule

/* hdl/read_ar_issue.sv */
module read_ar_issue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    beat_valid_i,
  input  dma_read_pkg::beat_cmd_t beat_cmd_i,
  output logic                    beat_take_o,
  output logic                    arvalid_o,
  output dma_read_pkg::ar_chan_t  ar_o,
  input  logic                    arready_i,
  output logic                    tag_wr_o,
  output dma_read_pkg::beat_tag_t tag_o,
  input  logic                    credit_return_i
);

  logic arvalid_q;
  dma_read_pkg::ar_chan_t ar_q;
  dma_read_pkg::beat_tag_t tag_q;
  dma_read_pkg::level_t credit_q;
  logic ar_xfer;
  logic ar_load;

  assign ar_xfer = arvalid_q && arready_i;

  // Only one request outstanding on AR, and only with a free buffer slot
  assign ar_load = beat_valid_i && !arvalid_q && (credit_q != '0);

  always_ff @(posedge clk)
  begin
    if (rst)
      arvalid_q <= 1'b0;
    else if (ar_load)
      arvalid_q <= 1'b1;
    else if (ar_xfer)
      arvalid_q <= 1'b0;
  end

  // Beat address to byte address
  always_ff @(posedge clk)
  begin
    if (ar_load)
    begin
      ar_q.addr <= {{(dma_read_pkg::AXI_ADDR_W - dma_read_pkg::BEAT_ADDR_W -
                      dma_read_pkg::BEAT_SHIFT){1'b0}},
                    beat_cmd_i.addr,
                    {dma_read_pkg::BEAT_SHIFT{1'b0}}};
      tag_q.mask <= beat_cmd_i.mask;
      tag_q.last <= beat_cmd_i.last;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      credit_q <= dma_read_pkg::level_t'(dma_read_pkg::FIFO_DEPTH);
    else
      credit_q <= credit_q - dma_read_pkg::level_t'(ar_xfer) +
                  dma_read_pkg::level_t'(credit_return_i);
  end

  assign arvalid_o   = arvalid_q;
  assign ar_o        = ar_q;
  assign beat_take_o = ar_xfer;
  assign tag_wr_o    = ar_xfer;
  assign tag_o       = tag_q;

  ar_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

  // Returns never outnumber the beats that were issued
  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_q <= dma_read_pkg::level_t'(dma_read_pkg::FIFO_DEPTH));

endmodule

/* hdl/read_return.sv */
module read_return (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            data_empty_i,
  input  logic [dma_read_pkg::DATA_W-1:0] data_i,
  input  dma_read_pkg::beat_tag_t         tag_i,
  input  logic                            dout_rdy_i,
  output logic                            pop_o,
  output logic                            credit_return_o,
  output dma_read_pkg::dout_beat_t        dout_o
);

  logic pop;
  logic [dma_read_pkg::DATA_W-1:0] data_q;
  dma_read_pkg::client_mask_t en_q;
  logic eop_q;
  logic credit_q;

  // Data and tag heads are popped as a pair
  assign pop = !data_empty_i && dout_rdy_i;

  always_ff @(posedge clk)
  begin
    if (pop)
      data_q <= data_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      en_q     <= '0;
      eop_q    <= 1'b0;
      credit_q <= 1'b0;
    end
    else
    begin
      en_q     <= tag_i.mask & {dma_read_pkg::NUM_CLIENTS{pop}};
      eop_q    <= tag_i.last & pop;
      credit_q <= pop;
    end
  end

  assign pop_o           = pop;
  assign credit_return_o = credit_q;
  assign dout_o.data     = data_q;
  assign dout_o.en       = en_q;
  assign dout_o.eop      = eop_q;

endmodule

/* hdl/dma_read_top.sv */
module dma_read_top (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  dma_read_pkg::client_mask_t                              read_req_i,
  input  dma_read_pkg::read_cmd_t [dma_read_pkg::NUM_CLIENTS-1:0] read_cmd_i,
  output dma_read_pkg::client_mask_t                              read_ack_o,
  output logic                                                    arvalid_o,
  output dma_read_pkg::ar_chan_t                                  ar_o,
  input  logic                                                    arready_i,
  input  logic                                                    rvalid_i,
  input  logic [dma_read_pkg::DATA_W-1:0]                         rdata_i,
  output logic                                                    rready_o,
  output dma_read_pkg::dout_beat_t                                dout_o,
  input  logic                                                    dout_rdy_i
);

  dma_read_pkg::client_mask_t grant;
  dma_read_pkg::beat_cmd_t beat_cmd;
  dma_read_pkg::beat_tag_t tag_in;
  dma_read_pkg::beat_tag_t tag_out;
  logic [dma_read_pkg::DATA_W-1:0] data_out;
  logic job_busy;
  logic beat_valid;
  logic beat_take;
  logic tag_wr;
  logic pop;
  logic credit_return;
  logic data_full;
  logic data_empty;

  read_arbiter arbiter_inst (
    .clk        (clk),
    .rst        (rst),
    .read_req_i (read_req_i),
    .job_busy_i (job_busy),
    .grant_o    (grant),
    .read_ack_o (read_ack_o)
  );

  read_job_regs job_regs_inst (
    .clk          (clk),
    .rst          (rst),
    .grant_i      (grant),
    .read_cmd_i   (read_cmd_i),
    .beat_take_i  (beat_take),
    .beat_valid_o (beat_valid),
    .beat_cmd_o   (beat_cmd),
    .job_busy_o   (job_busy)
  );

  read_ar_issue ar_issue_inst (
    .clk             (clk),
    .rst             (rst),
    .beat_valid_i    (beat_valid),
    .beat_cmd_i      (beat_cmd),
    .beat_take_o     (beat_take),
    .arvalid_o       (arvalid_o),
    .ar_o            (ar_o),
    .arready_i       (arready_i),
    .tag_wr_o        (tag_wr),
    .tag_o           (tag_in),
    .credit_return_i (credit_return)
  );

  // Credits keep this from filling, so rready stays high
  sync_fifo #(.WIDTH(dma_read_pkg::DATA_W)) data_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (rvalid_i),
    .din_i   (rdata_i),
    .rd_i    (pop),
    .dout_o  (data_out),
    .full_o  (data_full),
    .empty_o (data_empty)
  );

  sync_fifo #(.WIDTH($bits(dma_read_pkg::beat_tag_t))) tag_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (tag_wr),
    .din_i   (tag_in),
    .rd_i    (pop),
    .dout_o  (tag_out),
    .full_o  (),
    .empty_o ()
  );

  assign rready_o = !data_full;

  read_return return_inst (
    .clk             (clk),
    .rst             (rst),
    .data_empty_i    (data_empty),
    .data_i          (data_out),
    .tag_i           (tag_out),
    .dout_rdy_i      (dout_rdy_i),
    .pop_o           (pop),
    .credit_return_o (credit_return),
    .dout_o          (dout_o)
  );

endmodule

/* tests/mem_read_model.sv */
module mem_read_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            arvalid_i,
  input  dma_read_pkg::ar_chan_t          ar_i,
  output logic                            arready_o,
  output logic                            rvalid_o,
  output logic [dma_read_pkg::DATA_W-1:0] rdata_o,
  input  logic                            rready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rand_state;
  logic [dma_read_pkg::AXI_ADDR_W-1:0] addr_fifo [$];
  int due_fifo [$];
  int cycle;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Every address bit reaches both halves of the word
  function automatic logic [63:0] pattern_data(input logic [31:0] addr);
    return {addr * 32'h9E37_79B1, addr ^ 32'hC3A5_5A3C};
  endfunction

  initial
  begin
    rand_state = SEED;
    arready_o  = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    cycle      = 0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      addr_fifo.delete();
      due_fifo.delete();
    end
    else
    begin
      // Accepted reads wait 0 to 3 cycles, answered in order
      if (arvalid_i && arready_o)
      begin
        addr_fifo.push_back(ar_i.addr);
        due_fifo.push_back(cycle + int'((next_rand() >> 16) % 4));
      end
      if (rvalid_o && rready_i)
      begin
        void'(addr_fifo.pop_front());
        void'(due_fifo.pop_front());
      end
    end
    cycle = cycle + 1;
    #1;
    arready_o = !rst && (((next_rand() >> 16) % 4) != 0);
    if (addr_fifo.size() > 0 && due_fifo[0] <= cycle)
    begin
      rvalid_o = 1'b1;
      rdata_o  = pattern_data(addr_fifo[0]);
    end
    else
    begin
      rvalid_o = 1'b0;
    end
  end

endmodule

/* tests/tb_dma_read.sv */
module tb_dma_read;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_JOBS = 48;
  localparam int MAX_LEN = 6;
  localparam int SOLO_CLIENT = 9;
  localparam int SOLO_JOBS = 6;
  localparam int MAX_BEATS = NUM_JOBS * MAX_LEN + SOLO_JOBS;

  logic clk = 1'b0;
  logic rst;
  dma_read_pkg::client_mask_t read_req;
  dma_read_pkg::read_cmd_t [dma_read_pkg::NUM_CLIENTS-1:0] read_cmd;
  dma_read_pkg::client_mask_t read_ack;
  logic arvalid;
  dma_read_pkg::ar_chan_t ar;
  logic arready;
  logic rvalid;
  logic [dma_read_pkg::DATA_W-1:0] rdata;
  logic rready;
  dma_read_pkg::dout_beat_t dout;
  logic dout_rdy;

  logic [31:0] rand_state;
  logic [dma_read_pkg::AXI_ADDR_W-1:0] exp_addr [MAX_BEATS];
  logic [dma_read_pkg::DATA_W-1:0] exp_data [MAX_BEATS];
  dma_read_pkg::client_mask_t exp_mask [MAX_BEATS];
  logic exp_last [MAX_BEATS];
  int exp_count = 0;
  int ar_count = 0;
  int out_count = 0;
  int ack_count = 0;
  int next_client = 0;
  int cycle = 0;
  int last_ack [dma_read_pkg::NUM_CLIENTS];
  int ack_idx;
  int ack_gap;

  always #4 clk = ~clk;

  dma_read_top dma_read_top_inst (
    .clk        (clk),
    .rst        (rst),
    .read_req_i (read_req),
    .read_cmd_i (read_cmd),
    .read_ack_o (read_ack),
    .arvalid_o  (arvalid),
    .ar_o       (ar),
    .arready_i  (arready),
    .rvalid_i   (rvalid),
    .rdata_i    (rdata),
    .rready_o   (rready),
    .dout_o     (dout),
    .dout_rdy_i (dout_rdy)
  );

  mem_read_model #(.SEED(32'h8218_8f3f ^ 32'h5555_5555)) mem_inst (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (arvalid),
    .ar_i      (ar),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rready_i  (rready)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [63:0] pattern_data(input logic [31:0] addr);
    return {addr * 32'h9E37_79B1, addr ^ 32'hC3A5_5A3C};
  endfunction

  // First requester at or after the rotating start
  function automatic dma_read_pkg::client_mask_t rr_winner(
    input dma_read_pkg::client_mask_t req,
    input int from_idx
  );
    dma_read_pkg::client_mask_t pick;
    int idx;
    pick = '0;
    for (int k = dma_read_pkg::NUM_CLIENTS - 1; k >= 0; k--)
    begin
      idx = (from_idx + k) % dma_read_pkg::NUM_CLIENTS;
      if (req[idx])
        pick = dma_read_pkg::client_mask_t'(1) << idx;
    end
    return pick;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  // Start kept below 2**20 so a job never wraps the beat address
  task automatic load_cmd(input int c, input int max_len);
    read_cmd[c].start_addr = dma_read_pkg::BEAT_ADDR_W'(next_rand() >> 12);
    read_cmd[c].beat_len   = dma_read_pkg::BEAT_ADDR_W'((next_rand() >> 16) % max_len + 1);
  endtask

  // Expected AR addresses and output beats of an acked job
  task automatic record_job(input int c);
    logic [31:0] byte_addr;
    int len;
    byte_addr = 32'(read_cmd[c].start_addr) * dma_read_pkg::BEAT_BYTES;
    len = int'(read_cmd[c].beat_len);
    for (int k = 0; k < len; k++)
    begin
      exp_addr[exp_count] = byte_addr + 32'(k * dma_read_pkg::BEAT_BYTES);
      exp_data[exp_count] = pattern_data(exp_addr[exp_count]);
      exp_mask[exp_count] = dma_read_pkg::client_mask_t'(1) << c;
      exp_last[exp_count] = (k == len - 1);
      exp_count++;
    end
  endtask

  always_comb
  begin
    ack_idx = 0;
    for (int i = 0; i < dma_read_pkg::NUM_CLIENTS; i++)
    begin
      if (read_ack[i])
        ack_idx = i;
    end
    ack_gap = cycle - last_ack[ack_idx];
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (!rst)
    begin
      if (arvalid && arready)
        ar_count <= ar_count + 1;
      if (dout.en != '0)
        out_count <= out_count + 1;
      if (read_ack != '0)
      begin
        next_client <= (ack_idx + 1) % dma_read_pkg::NUM_CLIENTS;
        last_ack[ack_idx] <= cycle;
      end
    end
  end

  reset_quiet: assert property (@(posedge clk) $past(rst) |->
    read_ack == '0 && !arvalid && dout.en == '0)
    else report_error("outputs active during or right after reset");

  ack_order: assert property (@(posedge clk) disable iff (rst) read_ack != '0 |->
    read_ack == rr_winner($past(read_req, 2), next_client))
    else report_error("ack not one-hot or out of round-robin order");

  // Ack follows the request it answers by two edges
  ack_requested: assert property (@(posedge clk) disable iff (rst)
    (read_ack & ~$past(read_req, 2)) == '0)
    else report_error("ack to a client that was not requesting");

  ack_cooldown: assert property (@(posedge clk) disable iff (rst) read_ack != '0 |->
    ack_gap > dma_read_pkg::COOLDOWN_CYCLES)
    else report_error("client acked again within its cooldown");

  ar_addr_ok: assert property (@(posedge clk) disable iff (rst) arvalid && arready |->
    ar_count < exp_count && ar.addr == exp_addr[ar_count])
    else report_error("AR address does not match the expected beat");

  dout_ok: assert property (@(posedge clk) disable iff (rst) dout.en != '0 |->
    out_count < exp_count && dout.data == exp_data[out_count] &&
    dout.en == exp_mask[out_count] && dout.eop == exp_last[out_count])
    else report_error("output beat differs from the expected beat");

  no_stray_eop: assert property (@(posedge clk) disable iff (rst)
    dout.en == '0 |-> !dout.eop)
    else report_error("eop without an output beat");

  credit_ok: assert property (@(posedge clk) disable iff (rst)
    ar_count - out_count <= dma_read_pkg::FIFO_DEPTH + 1)
    else report_error("reads in flight exceed the credit pool");

  rready_held: assert property (@(posedge clk) disable iff (rst) rvalid |-> rready)
    else report_error("rready low while read data is offered");

  initial
  begin
    dma_read_pkg::client_mask_t dropped;
    dma_read_pkg::client_mask_t relaunch;
    int launched;
    int solo_left;
    rand_state = 32'h8218_8f3f;
    rst = 1'b1;
    read_req = '0;
    read_cmd = '0;
    dout_rdy = 1'b0;
    dropped = '0;
    for (int i = 0; i < dma_read_pkg::NUM_CLIENTS; i++)
      last_ack[i] = -100;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int c = 0; c < dma_read_pkg::NUM_CLIENTS; c++)
      load_cmd(c, MAX_LEN);
    read_req = '1;
    launched = dma_read_pkg::NUM_CLIENTS;
    while (ack_count < NUM_JOBS || out_count < exp_count)
    begin
      @(posedge clk);
      #1;
      relaunch = dropped;
      dropped = read_ack;
      for (int c = 0; c < dma_read_pkg::NUM_CLIENTS; c++)
      begin
        if (read_ack[c])
        begin
          record_job(c);
          ack_count++;
          read_req[c] = 1'b0;
        end
        else if (relaunch[c] && launched < NUM_JOBS)
        begin
          load_cmd(c, MAX_LEN);
          read_req[c] = 1'b1;
          launched++;
        end
      end
      // Long stall early in every 64 cycles drains the credits
      dout_rdy = (cycle % 64 >= 20) && (((next_rand() >> 16) % 8) < 5);
    end
    // One client alone with one-beat jobs, only the cooldown spaces its acks
    dout_rdy = 1'b1;
    load_cmd(SOLO_CLIENT, 1);
    read_req[SOLO_CLIENT] = 1'b1;
    solo_left = SOLO_JOBS;
    while (solo_left > 0 || out_count < exp_count)
    begin
      @(posedge clk);
      #1;
      if (read_ack[SOLO_CLIENT])
      begin
        record_job(SOLO_CLIENT);
        ack_count++;
        solo_left--;
        read_req[SOLO_CLIENT] = 1'b0;
      end
      else if (!read_req[SOLO_CLIENT] && solo_left > 0)
      begin
        load_cmd(SOLO_CLIENT, 1);
        read_req[SOLO_CLIENT] = 1'b1;
      end
    end
    repeat (4) @(posedge clk);
    if (ar_count == exp_count && !arvalid)
    begin
      $display("sim passed");
      $finish;
    end
    else
    begin
      $display("[ERROR] %0t %0d reads issued for %0d expected beats", $time, ar_count,
               exp_count);
      $display("sim failed");
      $fatal(1, "extra reads issued");
    end
  end

  // Budget grows with the beats that were issued
  initial
  begin
    @(negedge rst);
    while (cycle <= 40 * exp_count + 1000)
      @(posedge clk);
    $display("timeout: %0d of %0d beats delivered after %0d cycles", out_count, exp_count,
             cycle);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* all.f */
hdl/dma_read_pkg.sv
hdl/sync_fifo.sv
hdl/read_arbiter.sv
hdl/read_job_regs.sv
hdl/read_ar_issue.sv
hdl/read_return.sv
hdl/dma_read_top.sv
tests/mem_read_model.sv
tests/tb_dma_read.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_read \
  -f all.f --Mdir obj_dir
./obj_dir/Vtb_dma_read > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log
